//--- source/win_config.svh
`ifndef WIN_CONFIG_SVH
`define WIN_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// window and image geometry
////////////////////////////////////////////////////////////////////////////

// window side, odd.
// 11 is the full size, 3 and 5 also build.
`define WIN_K 11

// image width in pixels.
`define IMG_COLS 32

// image height in lines.
`define IMG_ROWS 16

`endif

//--- source/win_pkg.sv
`default_nettype none

package win_pkg;

  // greyscale sample.
  typedef logic [7:0] pixel_t;

  // column or row index inside a frame.
  typedef logic [9:0] coord_t;

  // box sum, wide enough for 121 x 255.
  typedef logic [15:0] sum_t;

  // handshake controller states.
  typedef enum logic [2:0] {
    IDLE,
    IN_ACK,
    CALC,
    OUT_REQ,
    OUT_DROP
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- source/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "win_config.svh"

module line_buffer (
  input  wire logic                               clk,
  input  wire logic                               rst_n,
  input  wire logic                               shift_en_i,
  input  wire win_pkg::pixel_t                    px_i,
  output win_pkg::pixel_t [`WIN_K-1:0]            col_o
);

  import win_pkg::*;

  localparam int K    = `WIN_K;
  localparam int COLS = `IMG_COLS;

  // one delay line per stored image row.
  // row_mem[r][COLS-1] is the oldest pixel of row r.
  pixel_t row_mem [K-1][COLS];

  ////////////////////////////////////////////////////////////////////////////
  // row delay chain
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < K-1; r++) begin
        for (int c = 0; c < COLS; c++) begin
          row_mem[r][c] <= '0;
        end
      end
    end else if (shift_en_i) begin
      // newest pixel enters the first line.
      row_mem[0][0] <= px_i;

      // the pixel falling out of one line feeds the next.
      for (int r = 1; r < K-1; r++) begin
        row_mem[r][0] <= row_mem[r-1][COLS-1];
      end

      for (int r = 0; r < K-1; r++) begin
        for (int c = 1; c < COLS; c++) begin
          row_mem[r][c] <= row_mem[r][c-1];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // aligned column
  ////////////////////////////////////////////////////////////////////////////

  // each tap is exactly COLS pushes older than the one before.
  always_comb begin
    col_o[0] = px_i;
    for (int r = 1; r < K; r++) begin
      col_o[r] = row_mem[r-1][COLS-1];
    end
  end

endmodule

`default_nettype wire

//--- source/window_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "win_config.svh"

module window_datapath (
  input  wire logic                                   clk,
  input  wire logic                                   rst_n,
  input  wire logic                                   shift_en_i,
  input  wire win_pkg::pixel_t [`WIN_K-1:0]           col_i,
  output win_pkg::pixel_t [`WIN_K*`WIN_K-1:0]         win_o,
  output logic                                        win_inside_o
);

  import win_pkg::*;

  localparam int     K        = `WIN_K;
  localparam coord_t LAST_COL = coord_t'(`IMG_COLS - 1);
  localparam coord_t LAST_ROW = coord_t'(`IMG_ROWS - 1);
  localparam coord_t EDGE     = coord_t'(K - 1);

  // taps[r][0] is the newest column, r follows col_i.
  pixel_t taps [K][K];

  // position of the next pixel to be accepted.
  coord_t col_cnt;
  coord_t row_cnt;

  ////////////////////////////////////////////////////////////////////////////
  // column shift window
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int r = 0; r < K; r++) begin
        for (int c = 0; c < K; c++) begin
          taps[r][c] <= '0;
        end
      end
    end else if (shift_en_i) begin
      for (int r = 0; r < K; r++) begin
        taps[r][0] <= col_i[r];
        for (int c = 1; c < K; c++) begin
          taps[r][c] <= taps[r][c-1];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // position counters
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      col_cnt      <= '0;
      row_cnt      <= '0;
      win_inside_o <= 1'b0;
    end else if (shift_en_i) begin
      // judged on the pixel being shifted in now.
      win_inside_o <= (col_cnt >= EDGE) && (row_cnt >= EDGE);

      if (col_cnt == LAST_COL) begin
        col_cnt <= '0;
        // frames follow back to back.
        if (row_cnt == LAST_ROW) begin
          row_cnt <= '0;
        end else begin
          row_cnt <= row_cnt + coord_t'(1);
        end
      end else begin
        col_cnt <= col_cnt + coord_t'(1);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // window output
  ////////////////////////////////////////////////////////////////////////////

  // top image row first, oldest column first within a row.
  always_comb begin
    for (int r = 0; r < K; r++) begin
      for (int c = 0; c < K; c++) begin
        win_o[r*K + c] = taps[K-1-r][K-1-c];
      end
    end
  end

endmodule

`default_nettype wire

//--- source/window_reduce.sv
`timescale 1ns/1ps
`default_nettype none

`include "win_config.svh"

module window_reduce (
  input  wire logic                                   clk,
  input  wire logic                                   rst_n,
  input  wire logic                                   calc_en_i,
  input  wire win_pkg::pixel_t [`WIN_K*`WIN_K-1:0]    win_i,
  output win_pkg::sum_t                               sum_o,
  output win_pkg::pixel_t                             max_o
);

  import win_pkg::*;

  localparam int K = `WIN_K;

  sum_t   row_sum [K];
  pixel_t row_max [K];
  sum_t   win_sum;
  pixel_t win_max;

  // first level, one partial per window row.
  always_comb begin
    for (int r = 0; r < K; r++) begin
      row_sum[r] = '0;
      row_max[r] = '0;
      for (int c = 0; c < K; c++) begin
        row_sum[r] = row_sum[r] + sum_t'(win_i[r*K + c]);
        if (win_i[r*K + c] > row_max[r]) begin
          row_max[r] = win_i[r*K + c];
        end
      end
    end
  end

  // second level across the rows.
  always_comb begin
    win_sum = '0;
    win_max = '0;
    for (int r = 0; r < K; r++) begin
      win_sum = win_sum + row_sum[r];
      if (row_max[r] > win_max) begin
        win_max = row_max[r];
      end
    end
  end

  // held until the next window is computed.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sum_o <= '0;
      max_o <= '0;
    end else if (calc_en_i) begin
      sum_o <= win_sum;
      max_o <= win_max;
    end
  end

endmodule

`default_nettype wire

//--- source/stream_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stream_ctrl (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic px_req_i,
  output logic      px_ack_o,
  output logic      res_req_o,
  input  wire logic res_ack_i,
  input  wire logic win_inside_i,
  output logic      shift_en_o,
  output logic      calc_en_o
);

  import win_pkg::*;

  ctrl_state_t state_q;
  ctrl_state_t state_d;

  ////////////////////////////////////////////////////////////////////////////
  // next state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // only reached with both handshakes back at rest.
        if (px_req_i) begin
          state_d = IN_ACK;
        end
      end
      IN_ACK: begin
        // win_inside is already updated by the shift into this state.
        if (!px_req_i) begin
          state_d = win_inside_i ? CALC : IDLE;
        end
      end
      CALC: begin
        state_d = OUT_REQ;
      end
      OUT_REQ: begin
        if (res_ack_i) begin
          state_d = OUT_DROP;
        end
      end
      OUT_DROP: begin
        if (!res_ack_i) begin
          state_d = IDLE;
        end
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // state and handshake outputs
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q   <= IDLE;
      px_ack_o  <= 1'b0;
      res_req_o <= 1'b0;
    end else begin
      state_q   <= state_d;
      px_ack_o  <= (state_d == IN_ACK);
      res_req_o <= (state_d == OUT_REQ);
    end
  end

  // pixel is taken on the edge that raises px_ack.
  assign shift_en_o = (state_q == IDLE) && px_req_i;

  // results are registered on the edge that raises res_req.
  assign calc_en_o  = (state_q == CALC);

endmodule

`default_nettype wire

//--- source/window_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "win_config.svh"

module window_filter_top (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            px_req_i,
  input  wire win_pkg::pixel_t px_data_i,
  output logic                 px_ack_o,
  output logic                 res_req_o,
  output win_pkg::sum_t        res_sum_o,
  output win_pkg::pixel_t      res_max_o,
  input  wire logic            res_ack_i
);

  import win_pkg::*;

  localparam int K = `WIN_K;

  logic             shift_en;
  logic             calc_en;
  logic             win_inside;
  pixel_t [K-1:0]   col_data;
  pixel_t [K*K-1:0] win;

  ////////////////////////////////////////////////////////////////////////////
  // datapath
  ////////////////////////////////////////////////////////////////////////////

  line_buffer line_buffer_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .shift_en_i (shift_en),
    .px_i       (px_data_i),
    .col_o      (col_data)
  );

  window_datapath window_datapath_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .shift_en_i   (shift_en),
    .col_i        (col_data),
    .win_o        (win),
    .win_inside_o (win_inside)
  );

  window_reduce window_reduce_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .calc_en_i (calc_en),
    .win_i     (win),
    .sum_o     (res_sum_o),
    .max_o     (res_max_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // handshake control
  ////////////////////////////////////////////////////////////////////////////

  stream_ctrl stream_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .px_req_i     (px_req_i),
    .px_ack_o     (px_ack_o),
    .res_req_o    (res_req_o),
    .res_ack_i    (res_ack_i),
    .win_inside_i (win_inside),
    .shift_en_o   (shift_en),
    .calc_en_o    (calc_en)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD_NS = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD_NS clk_o = ~clk_o;
  end

  // reset held for two rising edges.
  initial begin
    rst_n_o = 1'b0;
    repeat (2) @(posedge clk_o);
    #1 rst_n_o = 1'b1;
  end

endmodule

`default_nettype wire

//--- test/window_filter_assert.sv
`timescale 1ns/1ps
`default_nettype none

module window_filter_assert (
  input wire logic            clk,
  input wire logic            rst_n,
  input wire logic            px_req_i,
  input wire logic            px_ack_i,
  input wire logic            res_req_i,
  input wire logic            res_ack_i,
  input wire win_pkg::sum_t   res_sum_i,
  input wire win_pkg::pixel_t res_max_i
);

  ////////////////////////////////////////////////////////////////////////////
  // four-phase handshake rules
  ////////////////////////////////////////////////////////////////////////////

  px_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(px_ack_i) |-> $past(px_req_i))
    else $error("px_ack rose without px_req");

  res_ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(res_ack_i) |-> res_req_i)
    else $error("res_ack rose without res_req");

  res_req_held: assert property (@(posedge clk) disable iff (!rst_n)
    res_req_i && !res_ack_i |=> res_req_i)
    else $error("res_req dropped before res_ack");

  // result may not move under a pending request.
  res_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
    res_req_i |=> (!res_req_i || ($stable(res_sum_i) && $stable(res_max_i))))
    else $error("result data changed while res_req high");

  // input stays blocked until the result handshake is back at rest.
  input_stalled: assert property (@(posedge clk) disable iff (!rst_n)
    (res_req_i || res_ack_i) |-> !px_ack_i)
    else $error("px_ack high while a result is pending");

endmodule

bind window_filter_top window_filter_assert window_filter_assert_inst (
  .clk       (clk),
  .rst_n     (rst_n),
  .px_req_i  (px_req_i),
  .px_ack_i  (px_ack_o),
  .res_req_i (res_req_o),
  .res_ack_i (res_ack_i),
  .res_sum_i (res_sum_o),
  .res_max_i (res_max_o)
);

`default_nettype wire

//--- test/window_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "win_config.svh"

module window_filter_tb;

  import win_pkg::*;

  localparam int          K            = `WIN_K;
  localparam int          COLS         = `IMG_COLS;
  localparam int          ROWS         = `IMG_ROWS;
  localparam int          N_FRAMES     = 5;
  localparam int          PER_FRAME    = (COLS - K + 1) * (ROWS - K + 1);
  localparam int          N_RESULTS    = N_FRAMES * PER_FRAME;
  localparam int          CYCLE_LIMIT  = N_FRAMES * COLS * ROWS * 16;
  localparam int          STALL_CYCLES = 300;
  localparam int          STALL_INDEX  = 4 * PER_FRAME + 10;
  localparam logic [31:0] SEED         = 32'had8d_3467;

  logic   clk;
  logic   rst_n;
  logic   px_req_i;
  pixel_t px_data_i;
  logic   px_ack_o;
  logic   res_req_o;
  sum_t   res_sum_o;
  pixel_t res_max_o;
  logic   res_ack_i;

  pixel_t      image [N_FRAMES][ROWS][COLS];
  sum_t        exp_sum [N_RESULTS];
  pixel_t      exp_max [N_RESULTS];
  int          exp_accepted [N_RESULTS];
  logic [31:0] drv_rng;
  logic [31:0] rx_rng;
  int          accepted;
  int          cycle_count;

  tb_clock_gen tb_clock_gen_inst (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  window_filter_top window_filter_top_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .px_req_i  (px_req_i),
    .px_data_i (px_data_i),
    .px_ack_o  (px_ack_o),
    .res_req_o (res_req_o),
    .res_sum_o (res_sum_o),
    .res_max_o (res_max_o),
    .res_ack_i (res_ack_i)
  );

  ////////////////////////////////////////////////////////////////////////////
  // helpers and checks
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_sum(input string name, input sum_t got, input sum_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_max(input string name, input pixel_t got, input pixel_t exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  // inputs move 1 ns after the rising edge.
  task automatic step_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_random(inout logic [31:0] st);
    st = xorshift32(st);
    repeat (int'(st[1:0])) step_cycle();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // frame 2 saturated, frame 3 black, the rest random.
  task automatic build_frames();
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          drv_rng = xorshift32(drv_rng);
          if (f == 2) begin
            image[f][r][c] = 8'hff;
          end else if (f == 3) begin
            image[f][r][c] = 8'h00;
          end else begin
            image[f][r][c] = drv_rng[7:0];
          end
        end
      end
    end
  endtask

  // one result per lower-right corner inside the frame, raster order.
  task automatic build_expected();
    int     n;
    int     acc;
    pixel_t mx;
    pixel_t px;
    n = 0;
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int r = K - 1; r < ROWS; r++) begin
        for (int c = K - 1; c < COLS; c++) begin
          acc = 0;
          mx  = '0;
          for (int dr = 0; dr < K; dr++) begin
            for (int dc = 0; dc < K; dc++) begin
              px  = image[f][r - K + 1 + dr][c - K + 1 + dc];
              acc = acc + int'(px);
              if (px > mx) begin
                mx = px;
              end
            end
          end
          exp_sum[n]      = sum_t'(acc);
          exp_max[n]      = mx;
          exp_accepted[n] = f * COLS * ROWS + r * COLS + c + 1;
          n = n + 1;
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // handshake partners
  ////////////////////////////////////////////////////////////////////////////

  task automatic send_pixel(input pixel_t p);
    wait_random(drv_rng);
    px_data_i = p;
    px_req_i  = 1'b1;
    step_cycle();
    while (!px_ack_o) step_cycle();
    accepted = accepted + 1;
    wait_random(drv_rng);
    px_req_i = 1'b0;
    step_cycle();
    while (px_ack_o) step_cycle();
  endtask

  task automatic send_all();
    for (int f = 0; f < N_FRAMES; f++) begin
      for (int r = 0; r < ROWS; r++) begin
        for (int c = 0; c < COLS; c++) begin
          send_pixel(image[f][r][c]);
        end
      end
    end
  endtask

  // long hold on res_ack, the input side must stay blocked.
  task automatic hold_stall();
    repeat (STALL_CYCLES) begin
      step_cycle();
      check_flag("px_ack_o", px_ack_o, 1'b0);
      check_flag("res_req_o", res_req_o, 1'b1);
    end
  endtask

  task automatic take_result(input int idx);
    while (!res_req_o) step_cycle();
    if (accepted != exp_accepted[idx]) begin
      abort_run($sformatf("result %0d came after %0d accepted pixels instead of %0d",
                          idx, accepted, exp_accepted[idx]));
    end
    check_sum("res_sum_o", res_sum_o, exp_sum[idx]);
    check_max("res_max_o", res_max_o, exp_max[idx]);
    if (idx == STALL_INDEX) begin
      hold_stall();
    end else begin
      wait_random(rx_rng);
    end
    res_ack_i = 1'b1;
    step_cycle();
    while (res_req_o) step_cycle();
    wait_random(rx_rng);
    res_ack_i = 1'b0;
  endtask

  task automatic take_all();
    for (int i = 0; i < N_RESULTS; i++) begin
      take_result(i);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // run control
  ////////////////////////////////////////////////////////////////////////////

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count = cycle_count + 1;
    end
    abort_run($sformatf("timeout, no end of test after %0d cycles", cycle_count));
  end

  initial begin : stimulus
    px_req_i  = 1'b0;
    px_data_i = '0;
    res_ack_i = 1'b0;
    drv_rng   = SEED;
    rx_rng    = xorshift32(~SEED);
    accepted  = 0;
    build_frames();
    build_expected();

    @(posedge rst_n);
    step_cycle();
    check_flag("px_ack_o", px_ack_o, 1'b0);
    check_flag("res_req_o", res_req_o, 1'b0);

    fork
      send_all();
      take_all();
    join

    // nothing extra may follow the last result.
    repeat (8) step_cycle();
    if (!res_req_o && !px_ack_o) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("a stray handshake followed the last result");
    end
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+source
source/win_pkg.sv
source/line_buffer.sv
source/window_datapath.sv
source/window_reduce.sv
source/stream_ctrl.sv
source/window_filter_top.sv
test/tb_clock_gen.sv
test/window_filter_assert.sv
test/window_filter_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = window_filter_tb
FILELIST = compile.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
